// File: files.f
source/rob_pkg.sv
source/rob_alloc_if.sv
source/rob_ctrl.sv
source/rob_tail_alloc.sv
source/branch_fifo.sv
source/rob_commit.sv
source/rob_top.sv
sim/tb_clkgen.sv
sim/tb_rob_top.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_rob_top
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/tb_rob_top.sv
`timescale 1ns/1ps

module tb_rob_top import rob_pkg::*; ();

   localparam int BRNC_DEPTH = 2;
   localparam int WAIT_LIMIT = 20;   // cycles per wait loop

   logic                            clk;
   logic                            rst_n;
   logic [DISP_W-1:0]               disp_valid;
   logic [DISP_W-1:0]               disp_branch;
   logic                            disp_ready;
   rob_idx_t                        disp_base_idx;
   logic                            complete_valid;
   rob_idx_t                        complete_idx;
   logic                            resolve_valid;
   rob_idx_t                        resolve_idx;
   logic                            resolve_mispred;
   logic                            resolve_err;
   logic                            commit_valid;
   rob_idx_t                        commit_idx;
   logic [$clog2(BRNC_DEPTH+1)-1:0] brnc_count;

   // stimulus first, then the outputs expected before the next edge
   typedef struct {
      logic [DISP_W-1:0] dv;
      logic [DISP_W-1:0] db;
      int                cv;
      int                ci;
      int                rv;
      int                rm;
      int                ri;
      int                rdy;
      int                base;
      int                cmv;
      int                cmi;
      int                bc;
      int                err;
   } step_t;

   step_t steps[$];
   string phase;

   tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(4)) i_clkgen (.clk(clk), .rst_n(rst_n));

   rob_top #(.BRNC_DEPTH(BRNC_DEPTH)) i_dut (.*);

   task automatic abort_run();
      $display("FAIL: see errors above");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string what, input int got, input int exp);
      assert (got == exp)
      else
      begin
         $display("ERROR %0t: %s, %s is %0d, expected %0d", $time, phase, what, got, exp);
         abort_run();
      end
   endtask

   // one row per clock, driven at the rising edge, checked at the falling edge
   task automatic run_steps();
      step_t s;
      for (int i = 0; i < steps.size(); i++)
      begin
         s = steps[i];
         @(posedge clk);
         disp_valid      <= s.dv;
         disp_branch     <= s.db;
         complete_valid  <= (s.cv != 0);
         complete_idx    <= rob_idx_t'(s.ci);
         resolve_valid   <= (s.rv != 0);
         resolve_mispred <= (s.rm != 0);
         resolve_idx     <= rob_idx_t'(s.ri);
         @(negedge clk);
         phase = $sformatf("step %0d", i);
         check_val("disp_ready", int'(disp_ready), s.rdy);
         check_val("disp_base_idx", int'(disp_base_idx), s.base);
         check_val("commit_valid", int'(commit_valid), s.cmv);
         check_val("commit_idx", int'(commit_idx), s.cmi);
         check_val("brnc_count", int'(brnc_count), s.bc);
         check_val("resolve_err", int'(resolve_err), s.err);
      end
      steps.delete();
   endtask

   task automatic wait_reset_release();
      int n;
      n = 0;
      while (rst_n !== 1'b1 && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("reset was never released");
         abort_run();
      end
   endtask

   // single completion, then wait for that entry to retire
   task automatic complete_and_commit(input int idx);
      int n;
      @(posedge clk);
      complete_valid <= 1'b1;
      complete_idx   <= rob_idx_t'(idx);
      @(posedge clk);
      complete_valid <= 1'b0;
      @(negedge clk);
      n = 0;
      while (!commit_valid && n < WAIT_LIMIT)
      begin
         @(negedge clk);
         n++;
      end
      phase = $sformatf("drain of entry %0d", idx);
      if (!commit_valid)
      begin
         $display("entry %0d did not commit within %0d cycles", idx, WAIT_LIMIT);
         abort_run();
      end
      else
         check_val("commit_idx", int'(commit_idx), idx);
   endtask

   initial
   begin
      disp_valid      <= '0;
      disp_branch     <= '0;
      complete_valid  <= 1'b0;
      complete_idx    <= '0;
      resolve_valid   <= 1'b0;
      resolve_mispred <= 1'b0;
      resolve_idx     <= '0;

      // dv, db, cv, ci, rv, rm, ri, rdy, base, cmv, cmi, bc, err
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0});
      steps.push_back('{4'b1111, 4'b0000, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0});
      steps.push_back('{4'b0111, 4'b0000, 0, 0, 0, 0, 0, 1, 4, 0, 0, 0, 0});
      steps.push_back('{4'b0001, 4'b0000, 0, 0, 0, 0, 0, 1, 7, 0, 0, 0, 0});
      steps.push_back('{4'b0011, 4'b0001, 0, 0, 0, 0, 0, 1, 8, 0, 0, 0, 0});   // branch at 8
      steps.push_back('{4'b0001, 4'b0001, 0, 0, 0, 0, 0, 1, 10, 0, 0, 1, 0});  // branch at 10
      steps.push_back('{4'b0001, 4'b0001, 0, 0, 0, 0, 0, 0, 11, 0, 0, 2, 0});  // no branch room
      steps.push_back('{4'b0011, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 0, 0, 2, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 1, 0, 10, 1, 13, 0, 0, 2, 0}); // younger first
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 1, 0, 8, 1, 13, 0, 0, 2, 1});
      steps.push_back('{4'b1111, 4'b0000, 0, 0, 1, 1, 10, 0, 13, 0, 0, 1, 0}); // mispredict
      steps.push_back('{4'b0000, 4'b0000, 1, 11, 0, 0, 0, 1, 11, 0, 0, 0, 0}); // discarded entry
      steps.push_back('{4'b0000, 4'b0000, 1, 2, 0, 0, 0, 1, 11, 0, 0, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 1, 1, 0, 0, 0, 1, 11, 0, 0, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 1, 0, 0, 0, 0, 1, 11, 0, 0, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 1, 0, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 1, 1, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 1, 2, 0, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 0, 3, 0, 0});

      wait_reset_release();
      run_steps();

      for (int i = 3; i <= 10; i++)
         complete_and_commit(i);

      // head stops at the first discarded entry
      phase = "after drain";
      repeat (3)
      begin
         @(negedge clk);
         check_val("commit_valid", int'(commit_valid), 0);
         check_val("commit_idx", int'(commit_idx), 11);
      end

      steps.push_back('{4'b0111, 4'b0000, 0, 0, 0, 0, 0, 1, 11, 0, 11, 0, 0});
      for (int k = 0; k < 12; k++)
         steps.push_back('{4'b1111, 4'b0000, 0, 0, 0, 0, 0, 1, 14 + 4 * k, 0, 11, 0, 0});
      steps.push_back('{4'b0011, 4'b0010, 0, 0, 0, 0, 0, 1, 62, 0, 11, 0, 0}); // branch at 63
      steps.push_back('{4'b1111, 4'b0001, 0, 0, 1, 0, 63, 1, 0, 0, 11, 1, 0}); // pop and push
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 1, 0, 0, 1, 4, 0, 11, 1, 0});
      steps.push_back('{4'b0000, 4'b0000, 0, 0, 0, 0, 0, 1, 4, 0, 11, 0, 0});
      run_steps();

      $display("PASS: all tests");
      $finish;
   end

endmodule

// File: sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 4
) (
   output logic clk,
   output logic rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset held low for the first few rising edges
   initial
   begin
      rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

// File: source/rob_top.sv
`timescale 1ns/1ps

module rob_top import rob_pkg::*; #(
   parameter int BRNC_DEPTH = 2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [DISP_W-1:0]               disp_valid,
   input  logic [DISP_W-1:0]               disp_branch,
   output logic                            disp_ready,
   output rob_idx_t                        disp_base_idx,
   input  logic                            complete_valid,
   input  rob_idx_t                        complete_idx,
   input  logic                            resolve_valid,
   input  rob_idx_t                        resolve_idx,
   input  logic                            resolve_mispred,
   output logic                            resolve_err,
   output logic                            commit_valid,
   output rob_idx_t                        commit_idx,
   output logic [$clog2(BRNC_DEPTH+1)-1:0] brnc_count
);

   rob_cnt_t free_cnt;
   rob_cnt_t occ_cnt;
   rob_idx_t head_idx;    // oldest branch
   rob_idx_t rewind_idx;
   logic     empty;
   logic     pop;
   logic     flush;
   logic     rewind;
   logic     retire;

   rob_alloc_if i_alloc ();

   assign occ_cnt = rob_cnt_t'(ROB_DEPTH) - free_cnt;

   rob_ctrl #(
      .BRNC_DEPTH (BRNC_DEPTH)
   ) i_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .alloc           (i_alloc),
      .free_cnt        (free_cnt),
      .brnc_count      (brnc_count),
      .empty           (empty),
      .head_idx        (head_idx),
      .resolve_valid   (resolve_valid),
      .resolve_mispred (resolve_mispred),
      .resolve_idx     (resolve_idx),
      .disp_ready      (disp_ready),
      .pop             (pop),
      .flush           (flush),
      .rewind          (rewind),
      .rewind_idx      (rewind_idx),
      .resolve_err     (resolve_err)
   );

   rob_tail_alloc i_tail (
      .clk         (clk),
      .rst_n       (rst_n),
      .alloc       (i_alloc),
      .disp_valid  (disp_valid),
      .disp_branch (disp_branch),
      .rewind      (rewind),
      .rewind_idx  (rewind_idx),
      .head        (commit_idx),
      .retire      (retire),
      .free_cnt    (free_cnt),
      .tail        (disp_base_idx)
   );

   branch_fifo #(
      .BRNC_DEPTH (BRNC_DEPTH)
   ) i_brnc_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .alloc      (i_alloc),
      .pop        (pop),
      .flush      (flush),
      .head_idx   (head_idx),
      .brnc_count (brnc_count),
      .empty      (empty)
   );

   rob_commit i_commit (
      .clk            (clk),
      .rst_n          (rst_n),
      .complete_valid (complete_valid),
      .complete_idx   (complete_idx),
      .rewind         (rewind),
      .rewind_idx     (rewind_idx),
      .tail           (disp_base_idx),
      .alloc_cnt      (occ_cnt),
      .commit_valid   (commit_valid),
      .commit_idx     (commit_idx),
      .retire         (retire)
   );

endmodule

// File: source/rob_commit.sv
`timescale 1ns/1ps

module rob_commit import rob_pkg::*; (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     complete_valid,
   input  rob_idx_t complete_idx,
   input  logic     rewind,
   input  rob_idx_t rewind_idx,
   input  rob_idx_t tail,
   input  rob_cnt_t alloc_cnt,
   output logic     commit_valid,
   output rob_idx_t commit_idx,
   output logic     retire
);

   logic [ROB_DEPTH-1:0] done;
   logic [ROB_DEPTH-1:0] live;      // entry stays allocated past this edge
   logic [ROB_DEPTH-1:0] set_vec;
   logic [ROB_DEPTH-1:0] ret_vec;
   rob_idx_t             head;
   rob_idx_t             kill_span; // entries dropped by a rewind

   assign kill_span = tail - rewind_idx;

   // an entry is live when it sits in the occupied window
   // and is not younger than a mispredicted branch
   for (genvar i = 0; i < ROB_DEPTH; i++)
   begin : g_ent
      rob_idx_t off_head;
      rob_idx_t off_rew;

      assign off_head = rob_idx_t'(i) - head;
      assign off_rew  = rob_idx_t'(i) - rewind_idx;
      assign live[i]  = ({1'b0, off_head} < alloc_cnt)
                        && !(rewind && (off_rew < kill_span));
   end

   assign set_vec = complete_valid ? (ROB_DEPTH'(1) << complete_idx) : '0;
   assign ret_vec = retire ? (ROB_DEPTH'(1) << head) : '0;

   // free entries read as not done, so a new allocation starts clear
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         done <= '0;
      else
         done <= (done | set_vec) & live & ~ret_vec;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         head <= '0;
      else if (retire)
         head <= head + 1'b1;
   end

   // one retirement per cycle, no back-pressure
   assign commit_valid = (alloc_cnt != '0) && done[head];
   assign commit_idx   = head;
   assign retire       = commit_valid;

endmodule

// File: source/branch_fifo.sv
`timescale 1ns/1ps

module branch_fifo import rob_pkg::*; #(
   parameter int BRNC_DEPTH = 2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   rob_alloc_if.fifo                       alloc,
   input  logic                            pop,
   input  logic                            flush,
   output rob_idx_t                        head_idx,
   output logic [$clog2(BRNC_DEPTH+1)-1:0] brnc_count,
   output logic                            empty
);

   localparam int PTR_W = $clog2(BRNC_DEPTH);
   localparam int CNT_W = $clog2(BRNC_DEPTH + 1);

   rob_idx_t         mem [BRNC_DEPTH];
   logic [PTR_W-1:0] rd_ptr;
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] wr_ptr1;   // slot for a second branch
   logic [CNT_W-1:0] count;
   logic [1:0]       n_push;
   rob_idx_t         br0;
   rob_idx_t         br1;

   // first and second branch of the group, in slot order
   always_comb
   begin
      n_push = '0;
      br0    = '0;
      br1    = '0;
      for (int i = 0; i < DISP_W; i++)
      begin
         if (alloc.brnc_mask[i])
         begin
            if (n_push == 2'd0)
               br0 = alloc.slot_idx[i];
            else
               br1 = alloc.slot_idx[i];
            n_push = n_push + 1'b1;
         end
      end
      if (!alloc.accept)
         n_push = '0;
   end

   assign wr_ptr1 = wr_ptr + 1'b1;

   always_ff @(posedge clk)
   begin
      if (n_push != 2'd0)
         mem[wr_ptr] <= br0;
      if (n_push == 2'd2)
         mem[wr_ptr1] <= br1;
   end

   // pop and push may share an edge
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else if (flush)
      begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         rd_ptr <= rd_ptr + PTR_W'(pop);
         wr_ptr <= wr_ptr + PTR_W'(n_push);
         count  <= count - CNT_W'(pop) + CNT_W'(n_push);
      end
   end

   assign head_idx   = mem[rd_ptr];   // oldest unresolved branch
   assign brnc_count = count;
   assign empty      = (count == '0);

endmodule

// File: source/rob_tail_alloc.sv
`timescale 1ns/1ps

module rob_tail_alloc import rob_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   rob_alloc_if.alloc        alloc,
   input  logic [DISP_W-1:0] disp_valid,
   input  logic [DISP_W-1:0] disp_branch,
   input  logic              rewind,
   input  rob_idx_t          rewind_idx,
   input  rob_idx_t          head,
   input  logic              retire,
   output rob_cnt_t          free_cnt,
   output rob_idx_t          tail
);

   rob_cnt_t          occ;         // occupied entries
   rob_cnt_t          occ_nxt;
   disp_cnt_t         grp_cnt;
   logic [DISP_W-1:0] valid_mask;
   logic              run;
   rob_idx_t          br_off;      // branch distance from head

   // only the leading run of valid slots counts
   always_comb
   begin
      grp_cnt    = '0;
      valid_mask = '0;
      run        = 1'b1;
      for (int i = 0; i < DISP_W; i++)
      begin
         run           = run & disp_valid[i];
         valid_mask[i] = run;
         if (run)
            grp_cnt = grp_cnt + 1'b1;
      end
   end

   always_comb
   begin
      for (int i = 0; i < DISP_W; i++)
         alloc.slot_idx[i] = tail + rob_idx_t'(i);   // wraps at 63
   end

   assign alloc.brnc_mask = disp_branch & valid_mask;
   assign alloc.grp_cnt   = grp_cnt;

   assign br_off = rewind_idx - head - 1'b1;

   always_comb
   begin
      if (rewind)
         occ_nxt = {1'b0, br_off} + 1'b1;    // head up to the branch survives
      else if (alloc.accept)
         occ_nxt = occ + rob_cnt_t'(grp_cnt);
      else
         occ_nxt = occ;
      occ_nxt = occ_nxt - rob_cnt_t'(retire);
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tail <= '0;
         occ  <= '0;
      end
      else
      begin
         occ <= occ_nxt;
         if (rewind)
            tail <= rewind_idx;
         else if (alloc.accept)
            tail <= tail + rob_idx_t'(grp_cnt);
      end
   end

   assign free_cnt = rob_cnt_t'(ROB_DEPTH) - occ;

endmodule

// File: source/rob_ctrl.sv
`timescale 1ns/1ps

module rob_ctrl import rob_pkg::*; #(
   parameter int BRNC_DEPTH = 2
) (
   input  logic                            clk,
   input  logic                            rst_n,
   rob_alloc_if.ctrl                       alloc,
   input  rob_cnt_t                        free_cnt,
   input  logic [$clog2(BRNC_DEPTH+1)-1:0] brnc_count,
   input  logic                            empty,
   input  rob_idx_t                        head_idx,
   input  logic                            resolve_valid,
   input  logic                            resolve_mispred,
   input  rob_idx_t                        resolve_idx,
   output logic                            disp_ready,
   output logic                            pop,
   output logic                            flush,
   output logic                            rewind,
   output rob_idx_t                        rewind_idx,
   output logic                            resolve_err
);

   disp_cnt_t brnc_need;   // branches in this group
   logic      head_hit;    // resolution matches the oldest branch
   logic      mispred_ok;
   logic      rob_room;
   logic      brnc_room;

   always_comb
   begin
      brnc_need = '0;
      for (int i = 0; i < DISP_W; i++)
      begin
         if (alloc.brnc_mask[i])
            brnc_need = brnc_need + 1'b1;
      end
   end

   // branches must resolve oldest first
   assign head_hit   = resolve_valid && !empty && (resolve_idx == head_idx);
   assign mispred_ok = head_hit && resolve_mispred;

   assign rob_room  = free_cnt >= DISP_W;   // always room for a full group
   assign brnc_room = (int'(brnc_count) + int'(brnc_need)) <= BRNC_DEPTH;

   // the source holds its group while a flush is going on
   assign disp_ready   = rob_room && brnc_room && !mispred_ok;
   assign alloc.accept = disp_ready && (alloc.grp_cnt != '0);

   assign pop        = head_hit && !resolve_mispred;
   assign flush      = mispred_ok;
   assign rewind     = mispred_ok;
   assign rewind_idx = resolve_idx + 1'b1;  // wraps at 63

   // wrong order or nothing pending
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         resolve_err <= 1'b0;
      else
         resolve_err <= resolve_valid && !head_hit;
   end

endmodule

// File: source/rob_alloc_if.sv
`timescale 1ns/1ps

// one dispatch group, from the tail allocator to control and branch FIFO
interface rob_alloc_if import rob_pkg::*; ();

   rob_idx_t [DISP_W-1:0] slot_idx;   // tail+i per slot
   logic [DISP_W-1:0]     brnc_mask;  // branch flags, valid slots only
   disp_cnt_t             grp_cnt;    // contiguous valid slots from slot 0
   logic                  accept;     // group taken at this edge

   modport alloc (
      output slot_idx,
      output brnc_mask,
      output grp_cnt,
      input  accept
   );

   modport ctrl (
      input  brnc_mask,
      input  grp_cnt,
      output accept
   );

   modport fifo (
      input  slot_idx,
      input  brnc_mask,
      input  accept
   );

endinterface

// File: source/rob_pkg.sv
package rob_pkg;

   // ROB index, 64 entries
   localparam int ROB_IDX_W = 6;
   localparam int ROB_DEPTH = 1 << ROB_IDX_W;

   // slots per dispatch group
   localparam int DISP_W = 4;

   typedef logic [ROB_IDX_W-1:0] rob_idx_t;

   // 0..DISP_W slots
   typedef logic [2:0] disp_cnt_t;

   // 0..ROB_DEPTH entries, one bit wider than an index
   typedef logic [ROB_IDX_W:0] rob_cnt_t;

endpackage
